/* Makefile */
TOP = tb_fifo_std

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f tb.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Test failed" sim.log; then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "Test passed" sim.log; then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

/* fifo_consts.svh */
`ifndef FIFO_CONSTS_SVH
`define FIFO_CONSTS_SVH

// storage geometry, depth must be a power of two
`define FIFO_DEPTH 32
`define FIFO_AW 5           // log2 of depth
`define FIFO_CW 6           // count runs 0..depth

// payload fields
`define FIFO_DATA_W 16
`define FIFO_TAG_W 4

// fixed thresholds, each within 1..depth-1
`define FIFO_AFULL_TH 20    // almost full when count >= this
`define FIFO_AEMPTY_TH 5    // almost empty when count <= this

// depths below this use a one-hot count for empty/full
`define FIFO_ONEHOT_LIMIT 8

`endif

/* fifo_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

`include "fifo_consts.svh"

module fifo_ctrl
    import fifo_status_pkg::*;
(
    input  wire                clk,
    input  wire                rst_n,
    input  wire                wen,
    input  wire                ren,
    output fifo_flags_t        flags,
    output fifo_cnt_t          count,
    output logic               ram_wen,
    output logic [`FIFO_AW-1:0] ram_waddr,
    output logic               ram_ren,
    output logic [`FIFO_AW-1:0] ram_raddr
);

    // thresholds shifted by one, so the next flag value comes from
    // the count before it is stepped
    localparam fifo_cnt_t TOP_CNT = fifo_cnt_t'(`FIFO_DEPTH - 1);
    localparam fifo_cnt_t ONE_CNT = fifo_cnt_t'(1);
    localparam fifo_cnt_t AE_LO   = fifo_cnt_t'(`FIFO_AEMPTY_TH - 1);
    localparam fifo_cnt_t AE_HI   = fifo_cnt_t'(`FIFO_AEMPTY_TH + 1);
    localparam fifo_cnt_t AF_LO   = fifo_cnt_t'(`FIFO_AFULL_TH - 1);
    localparam fifo_cnt_t AF_HI   = fifo_cnt_t'(`FIFO_AFULL_TH + 1);

    logic               do_wr;      // accepted write
    logic               do_rd;      // accepted read
    logic               inc;        // net count change +1
    logic               dec;        // net count change -1
    logic               cnt_is_top; // count == depth-1
    logic               cnt_is_one; // count == 1
    fifo_flags_t        flags_nxt;
    fifo_cnt_t          count_nxt;
    logic [`FIFO_AW-1:0] wptr;
    logic [`FIFO_AW-1:0] rptr;

    // requests qualified with the registered flags
    assign do_wr = wen & ~flags.full;
    assign do_rd = ren & ~flags.empty;

    // write and read together leave the count alone
    assign inc = do_wr & ~do_rd;
    assign dec = do_rd & ~do_wr;

    generate
        if (`FIFO_DEPTH < `FIFO_ONEHOT_LIMIT) begin : g_onehot
            // bit i set when i words are stored
            logic [`FIFO_DEPTH:0] cnt_oh;

            always_ff @(posedge clk or negedge rst_n)
            begin
                if (!rst_n)
                    cnt_oh <= {{`FIFO_DEPTH{1'b0}}, 1'b1};
                else if (inc)
                    cnt_oh <= {cnt_oh[`FIFO_DEPTH-1:0], 1'b0}; // shift up
                else if (dec)
                    cnt_oh <= {1'b0, cnt_oh[`FIFO_DEPTH:1]};   // shift down
            end

            assign cnt_is_top = cnt_oh[`FIFO_DEPTH-1];
            assign cnt_is_one = cnt_oh[1];
        end
        else begin : g_binary
            assign cnt_is_top = (count == TOP_CNT);
            assign cnt_is_one = (count == ONE_CNT);
        end
    endgenerate

    // next count and flags from the present count
    always_comb
    begin
        flags_nxt = flags;
        count_nxt = count;
        if (inc)
        begin
            flags_nxt.empty        = 1'b0;
            flags_nxt.full         = cnt_is_top;
            flags_nxt.almost_empty = (count <= AE_LO);
            flags_nxt.almost_full  = (count >= AF_LO);
            count_nxt              = count + 1'b1;
        end
        else if (dec)
        begin
            flags_nxt.empty        = cnt_is_one;
            flags_nxt.full         = 1'b0;
            flags_nxt.almost_empty = (count <= AE_HI);
            flags_nxt.almost_full  = (count >= AF_HI);
            count_nxt              = count - 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            flags <= FIFO_FLAGS_RST;
            count <= '0;
        end
        else
        begin
            flags <= flags_nxt;
            count <= count_nxt;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            wptr <= '0;
        else if (do_wr)
            wptr <= wptr + 1'b1;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            rptr <= '0;
        else if (do_rd)
            rptr <= rptr + 1'b1;
    end

    // ram strobes, never the same slot in one cycle since
    // a read needs a stored word and a write needs a free one
    assign ram_wen   = do_wr;
    assign ram_waddr = wptr;
    assign ram_ren   = do_rd;
    assign ram_raddr = rptr;

endmodule

`default_nettype wire

/* fifo_payload_pkg.sv */
`default_nettype none

`include "fifo_consts.svh"

package fifo_payload_pkg;

    // framed word carried through the fifo
    // last marks the final word of a frame
    typedef struct packed {
        logic                    last;
        logic [`FIFO_TAG_W-1:0]  tag;
        logic [`FIFO_DATA_W-1:0] data;
    } fifo_word_t;

endpackage

`default_nettype wire

/* fifo_ram.sv */
`timescale 1ns/10ps
`default_nettype none

`include "fifo_consts.svh"

module fifo_ram
    import fifo_payload_pkg::*;
#(
    parameter type word_t = fifo_word_t
)
(
    input  wire                 clk,
    input  wire                 wen,
    input  wire [`FIFO_AW-1:0]  waddr,
    input  word_t               din,
    input  wire                 ren,
    input  wire [`FIFO_AW-1:0]  raddr,
    output word_t               dout
);

    word_t mem [`FIFO_DEPTH];

    // synchronous write port
    always_ff @(posedge clk)
    begin
        if (wen)
            mem[waddr] <= din;
    end

    // read register, one cycle latency
    // holds the last word until the next read
    always_ff @(posedge clk)
    begin
        if (ren)
            dout <= mem[raddr];
    end

endmodule

`default_nettype wire

/* fifo_status_pkg.sv */
`default_nettype none

`include "fifo_consts.svh"

package fifo_status_pkg;

    // occupancy flags, all registered in the controller
    typedef struct packed {
        logic empty;
        logic full;
        logic almost_empty;
        logic almost_full;
    } fifo_flags_t;

    // stored word count, one bit wider than the address
    typedef logic [`FIFO_CW-1:0] fifo_cnt_t;

    // value the flags take out of reset
    localparam fifo_flags_t FIFO_FLAGS_RST = '{
        empty:        1'b1,
        full:         1'b0,
        almost_empty: 1'b1,
        almost_full:  1'b0
    };

endpackage

`default_nettype wire

/* fifo_std.sv */
`timescale 1ns/10ps
`default_nettype none

`include "fifo_consts.svh"

module fifo_std
    import fifo_status_pkg::*;
    import fifo_payload_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  wire         wen,
    input  fifo_word_t  din,
    input  wire         ren,
    output fifo_word_t  dout,    // valid the cycle after an accepted read
    output fifo_flags_t flags,
    output fifo_cnt_t   count
);

    // controller to ram
    logic                ram_wen;
    logic [`FIFO_AW-1:0] ram_waddr;
    logic                ram_ren;
    logic [`FIFO_AW-1:0] ram_raddr;

    fifo_ctrl fifo_ctrl_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .wen       (wen),
        .ren       (ren),
        .flags     (flags),
        .count     (count),
        .ram_wen   (ram_wen),
        .ram_waddr (ram_waddr),
        .ram_ren   (ram_ren),
        .ram_raddr (ram_raddr)
    );

    // payload goes straight into the ram, ram output is dout
    fifo_ram #(
        .word_t (fifo_word_t)
    ) fifo_ram_inst (
        .clk   (clk),
        .wen   (ram_wen),
        .waddr (ram_waddr),
        .din   (din),
        .ren   (ram_ren),
        .raddr (ram_raddr),
        .dout  (dout)
    );

endmodule

`default_nettype wire

/* fifo_std_sva.sv */
`timescale 1ns/10ps
`default_nettype none

`include "fifo_consts.svh"

module fifo_std_sva
    import fifo_status_pkg::*;
(
    input wire         clk,
    input wire         rst_n,
    input fifo_flags_t flags,
    input fifo_cnt_t   count,
    input wire         ram_wen,
    input wire         ram_ren
);

    a_not_empty_and_full: assert property (@(posedge clk) disable iff (!rst_n)
        !(flags.empty && flags.full))
        else $error("empty and full are set together");

    // empty and full must track the stored count
    a_empty_is_zero: assert property (@(posedge clk) disable iff (!rst_n)
        flags.empty == (count == '0))
        else $error("empty disagrees with count %0d", count);

    a_full_is_depth: assert property (@(posedge clk) disable iff (!rst_n)
        flags.full == (count == fifo_cnt_t'(`FIFO_DEPTH)))
        else $error("full disagrees with count %0d", count);

    // strobes judged against the stored count, not the flag that gates them
    a_no_write_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        ram_wen |-> (count != fifo_cnt_t'(`FIFO_DEPTH)))
        else $error("ram write strobe while full");

    a_no_read_when_empty: assert property (@(posedge clk) disable iff (!rst_n)
        ram_ren |-> (count != '0))
        else $error("ram read strobe while empty");

endmodule

bind fifo_ctrl fifo_std_sva fifo_std_sva_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .flags   (flags),
    .count   (count),
    .ram_wen (ram_wen),
    .ram_ren (ram_ren)
);

`default_nettype wire

/* tb.f */
+incdir+.
fifo_status_pkg.sv
fifo_payload_pkg.sv
fifo_ctrl.sv
fifo_ram.sv
fifo_std.sv
fifo_std_sva.sv
tb_fifo_std.sv

/* tb_fifo_std.sv */
`timescale 1ns/10ps
`default_nettype none

`include "fifo_consts.svh"

module tb_fifo_std
    import fifo_status_pkg::*;
    import fifo_payload_pkg::*;
();

    typedef enum logic [1:0] {OP_WR, OP_RD, OP_BOTH, OP_DRAIN} op_t;

    // one table row, end_cnt is the count expected after the last repeat
    typedef struct packed {
        op_t        op;
        logic [7:0] reps;
        logic [7:0] end_cnt;
    } step_t;

    localparam int NSTEPS = 9;
    localparam int DRAIN_TIMEOUT = 2 * `FIFO_DEPTH;

    logic        clk;
    logic        rst_n;
    logic        wen;
    logic        ren;
    fifo_word_t  din;
    fifo_word_t  dout;
    fifo_flags_t flags;
    fifo_cnt_t   count;

    step_t       steps [NSTEPS];
    fifo_word_t  model_q [$];       // reference fifo contents
    fifo_word_t  exp_dout;
    logic        dout_known;        // no read accepted yet, dout still X
    logic [15:0] lfsr;
    int          checks;
    int          errors;

    fifo_std fifo_std_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .wen   (wen),
        .din   (din),
        .ren   (ren),
        .dout  (dout),
        .flags (flags),
        .count (count)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_word(output fifo_word_t w);
        logic [$bits(fifo_word_t)-1:0] bits;
        for (int i = 0; i < $bits(fifo_word_t); i++)
        begin
            lfsr = lfsr_next(lfsr);
            bits[i] = lfsr[0];  // one step per bit
        end
        w = bits;
    endtask

    function automatic fifo_flags_t expected_flags(input int n);
        fifo_flags_t f;
        f.empty        = (n == 0);
        f.full         = (n == `FIFO_DEPTH);
        f.almost_empty = (n <= `FIFO_AEMPTY_TH);
        f.almost_full  = (n >= `FIFO_AFULL_TH);
        return f;
    endfunction

    task automatic check_outputs();
        fifo_flags_t ef;
        ef = expected_flags(model_q.size());
        checks++;
        if (count !== fifo_cnt_t'(model_q.size()))
        begin
            $display("Mismatch at %0t: count %0d, expected %0d",
                     $time, count, model_q.size());
            errors++;
        end
        if (flags !== ef)
        begin
            $display("Mismatch at %0t: flags %b, expected %b", $time, flags, ef);
            errors++;
        end
        if (dout_known && (dout !== exp_dout))
        begin
            $display("Mismatch at %0t: dout %h, expected %h", $time, dout, exp_dout);
            errors++;
        end
    endtask

    // called on a falling edge, drives one request and checks after the next edge
    task automatic run_cycle(input logic wr, input logic rd);
        fifo_word_t w;
        logic       take_rd;
        logic       take_wr;
        random_word(w);
        take_rd = rd && (model_q.size() != 0);
        take_wr = wr && (model_q.size() != `FIFO_DEPTH);
        if (take_rd)
        begin
            exp_dout = model_q.pop_front();
            dout_known = 1'b1;
        end
        if (take_wr)
            model_q.push_back(w);
        wen = wr;
        ren = rd;
        din = w;
        @(negedge clk);
        check_outputs();
    endtask

    task automatic drain_until_empty();
        int cycles;
        cycles = 0;
        while (!flags.empty && (cycles < DRAIN_TIMEOUT))
        begin
            run_cycle(1'b0, 1'b1);
            cycles++;
        end
        if (!flags.empty)
        begin
            $display("Timeout at %0t: fifo still not empty after %0d reads",
                     $time, cycles);
            errors++;
        end
    endtask

    initial
    begin
        int err_before;
        rst_n = 1'b0;
        wen = 1'b0;
        ren = 1'b0;
        din = '0;
        lfsr = 16'd39906;
        checks = 0;
        errors = 0;
        dout_known = 1'b0;
        exp_dout = '0;

        steps = '{
            '{OP_WR,    8'd33, 8'd32},  // fill, last write dropped
            '{OP_WR,    8'd3,  8'd32},  // writes while full
            '{OP_BOTH,  8'd2,  8'd31},  // read only at full
            '{OP_RD,    8'd40, 8'd0},   // read out, extra reads at empty
            '{OP_BOTH,  8'd3,  8'd1},   // write only at empty
            '{OP_WR,    8'd11, 8'd12},
            '{OP_BOTH,  8'd10, 8'd12},  // mid count, count holds
            '{OP_DRAIN, 8'd1,  8'd0},
            '{OP_RD,    8'd3,  8'd0}
        };

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        err_before = errors;
        check_outputs();
        $display("test 0 reset state: %0d errors", errors - err_before);

        for (int s = 0; s < NSTEPS; s++)
        begin
            err_before = errors;
            if (steps[s].op == OP_DRAIN)
                drain_until_empty();
            else
                for (int r = 0; r < int'(steps[s].reps); r++)
                    run_cycle(steps[s].op != OP_RD, steps[s].op != OP_WR);
            if (count !== fifo_cnt_t'(steps[s].end_cnt))
            begin
                $display("Mismatch at %0t: count %0d after step, table says %0d",
                         $time, count, steps[s].end_cnt);
                errors++;
            end
            $display("test %0d %s x%0d: %0d errors", s + 1, steps[s].op.name(),
                     steps[s].reps, errors - err_before);
        end

        wen = 1'b0;
        ren = 1'b0;
        @(negedge clk);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire
